//--- design/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu (
  input wire clk,
  input wire rst,
  input wire progWe,
  input wire cpuPkg::word_t progAddr,
  input wire cpuPkg::word_t progData,
  output cpuPkg::word_t pc,
  output logic hlt,
  output logic wbEn,
  output cpuPkg::regIdx_t wbReg,
  output cpuPkg::word_t wbData
);

  // Branch resolution
  logic redirect;
  cpuPkg::word_t target;

  // Fetch to decode
  cpuPkg::word_t instrD;
  cpuPkg::word_t pcPlus2D;
  logic validD;

  // Write back into the register file
  logic regWe;
  cpuPkg::regIdx_t regNum;
  cpuPkg::word_t regData;

  decodeExecuteIf dx ();
  executeResultIf xr ();

  fetchUnit fetch (
    .clk(clk), .rst(rst),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .redirect(redirect), .target(target),
    .pc(pc), .instrD(instrD), .pcPlus2D(pcPlus2D), .validD(validD)
  );

  // Redirect doubles as the decode flush
  decodeStage decode (
    .clk(clk), .rst(rst),
    .instr(instrD), .pcPlus2(pcPlus2D), .valid(validD), .flush(redirect),
    .regWe(regWe), .regNum(regNum), .regData(regData),
    .dx(dx)
  );

  executeStage execute (
    .clk(clk), .rst(rst),
    .dx(dx), .xr(xr),
    .redirect(redirect), .target(target)
  );

  resultStage result (
    .clk(clk), .rst(rst),
    .xr(xr),
    .regWe(regWe), .regNum(regNum), .regData(regData),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
    .hlt(hlt)
  );

endmodule

`default_nettype wire

//--- design/cpuPkg.sv
`default_nettype none

package cpuPkg;

  ////////////////////
  // Widths with a meaning
  ////////////////////

  // Data, instruction and address word
  typedef logic [15:0] word_t;
  // Register number, sixteen entries
  typedef logic [3:0] regIdx_t;
  // Z, V, N from the top bit down
  typedef logic [2:0] flags_t;
  // Branch condition field
  typedef logic [2:0] cond_t;
  typedef logic [3:0] opcode_t;

  // Bit positions inside flags_t
  localparam int FLAG_Z = 2;
  localparam int FLAG_V = 1;
  localparam int FLAG_N = 0;

  ////////////////////
  // Opcodes
  ////////////////////

  localparam opcode_t OP_ADD = 4'd0;
  localparam opcode_t OP_SUB = 4'd1;
  localparam opcode_t OP_XOR = 4'd2;
  localparam opcode_t OP_SLL = 4'd4;
  localparam opcode_t OP_SRA = 4'd5;
  localparam opcode_t OP_LLB = 4'd10;
  localparam opcode_t OP_LHB = 4'd11;
  localparam opcode_t OP_B   = 4'd12;
  localparam opcode_t OP_HLT = 4'd15;

  // Branch conditions, code 111 is always taken
  localparam cond_t COND_NE = 3'b000;
  localparam cond_t COND_EQ = 3'b001;
  localparam cond_t COND_GT = 3'b010;
  localparam cond_t COND_LT = 3'b011;
  localparam cond_t COND_GE = 3'b100;
  localparam cond_t COND_LE = 3'b101;
  localparam cond_t COND_OV = 3'b110;

endpackage

`default_nettype wire

//--- design/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Instruction memory size in 16-bit words
// Must stay a power of two
`define CPU_IMEM_DEPTH 256

// First fetch address after reset
`define CPU_RESET_PC 16'h0000

`endif

//--- design/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
  input wire clk,
  input wire rst,
  input wire cpuPkg::word_t instr,
  input wire cpuPkg::word_t pcPlus2,
  input wire valid,
  // Taken branch in execute kills this slot
  input wire flush,
  // Register file write from the result stage
  input wire regWe,
  input wire cpuPkg::regIdx_t regNum,
  input wire cpuPkg::word_t regData,
  decodeExecuteIf.source dx
);

  cpuPkg::opcode_t op;
  cpuPkg::regIdx_t rd;
  cpuPkg::regIdx_t rsNum;
  cpuPkg::regIdx_t rtNum;
  cpuPkg::regIdx_t rtRead;
  cpuPkg::word_t rsVal;
  cpuPkg::word_t rtVal;
  cpuPkg::word_t regs [16];

  ////////////////////
  // Field split
  ////////////////////

  assign op = instr[15:12];
  assign rd = instr[11:8];
  assign rsNum = instr[7:4];
  assign rtNum = instr[3:0];

  // Byte loads merge into the old rd, so read it on the rt port
  assign rtRead = (op == cpuPkg::OP_LLB || op == cpuPkg::OP_LHB) ? rd : rtNum;

  ////////////////////
  // Register file
  ////////////////////

  always_ff @(posedge clk) begin
    if (regWe) begin
      regs[regNum] <= regData;
    end
  end

  // Same-cycle write is visible to the read
  assign rsVal = (regWe && regNum == rsNum) ? regData : regs[rsNum];
  assign rtVal = (regWe && regNum == rtRead) ? regData : regs[rtRead];

  // Decode/execute register, valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      dx.valid <= 1'b0;
    end else begin
      dx.valid <= valid && !flush;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    dx.op <= op;
    dx.rd <= rd;
    dx.rsNum <= rsNum;
    dx.rsVal <= rsVal;
    dx.rtVal <= rtVal;
    dx.imm8 <= instr[7:0];
    // Condition overlaps the top of rd
    dx.cond <= instr[11:9];
    dx.offset <= instr[8:0];
    dx.pcPlus2 <= pcPlus2;
  end

endmodule

`default_nettype wire

//--- design/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
  input wire clk,
  input wire rst,
  decodeExecuteIf.sink dx,
  executeResultIf.source xr,
  output logic redirect,
  output cpuPkg::word_t target
);

  cpuPkg::regIdx_t rtNum;
  logic fwdRs;
  logic fwdRt;
  cpuPkg::word_t opA;
  cpuPkg::word_t opB;
  cpuPkg::word_t aluOut;
  logic [3:0] shAmt;
  logic writes;
  logic setsAll;
  logic setsZ;
  logic ovfl;
  logic taken;
  cpuPkg::flags_t flags;

  ////////////////////
  // Forwarding
  ////////////////////

  // rt field sits in imm8
  // Byte loads use rd instead
  assign rtNum = (dx.op == cpuPkg::OP_LLB || dx.op == cpuPkg::OP_LHB) ? dx.rd : dx.imm8[3:0];
  // Older instruction now in the result stage
  assign fwdRs = xr.valid && xr.wrEn && xr.rd == dx.rsNum;
  assign fwdRt = xr.valid && xr.wrEn && xr.rd == rtNum;
  assign opA = fwdRs ? xr.data : dx.rsVal;
  assign opB = fwdRt ? xr.data : dx.rtVal;
  assign shAmt = dx.imm8[3:0];

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    aluOut = opA;
    writes = 1'b1;
    case (dx.op)
      cpuPkg::OP_ADD: aluOut = opA + opB;
      cpuPkg::OP_SUB: aluOut = opA - opB;
      cpuPkg::OP_XOR: aluOut = opA ^ opB;
      cpuPkg::OP_SLL: aluOut = opA << shAmt;
      cpuPkg::OP_SRA: aluOut = $signed(opA) >>> shAmt;
      cpuPkg::OP_LLB: aluOut = {opB[15:8], dx.imm8};
      cpuPkg::OP_LHB: aluOut = {dx.imm8, opB[7:0]};
      // B, HLT and unused codes
      default: writes = 1'b0;
    endcase
  end

  // Signed overflow of the wrapped result
  always_comb begin
    ovfl = 1'b0;
    if (dx.op == cpuPkg::OP_ADD) begin
      ovfl = (opA[15] == opB[15]) && (aluOut[15] != opA[15]);
    end else if (dx.op == cpuPkg::OP_SUB) begin
      ovfl = (opA[15] != opB[15]) && (aluOut[15] != opA[15]);
    end
  end

  // Flag register
  assign setsAll = dx.op == cpuPkg::OP_ADD || dx.op == cpuPkg::OP_SUB;
  assign setsZ = setsAll || dx.op == cpuPkg::OP_XOR || dx.op == cpuPkg::OP_SLL ||
                 dx.op == cpuPkg::OP_SRA;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (dx.valid) begin
      if (setsZ) begin
        flags[cpuPkg::FLAG_Z] <= aluOut == '0;
      end
      if (setsAll) begin
        flags[cpuPkg::FLAG_V] <= ovfl;
        flags[cpuPkg::FLAG_N] <= aluOut[15];
      end
    end
  end

  ////////////////////
  // Branch
  ////////////////////

  always_comb begin
    case (dx.cond)
      cpuPkg::COND_NE: taken = !flags[cpuPkg::FLAG_Z];
      cpuPkg::COND_EQ: taken = flags[cpuPkg::FLAG_Z];
      cpuPkg::COND_GT: taken = !flags[cpuPkg::FLAG_Z] && !flags[cpuPkg::FLAG_N];
      cpuPkg::COND_LT: taken = flags[cpuPkg::FLAG_N];
      cpuPkg::COND_GE: taken = flags[cpuPkg::FLAG_Z] || !flags[cpuPkg::FLAG_N];
      cpuPkg::COND_LE: taken = flags[cpuPkg::FLAG_N] || flags[cpuPkg::FLAG_Z];
      cpuPkg::COND_OV: taken = flags[cpuPkg::FLAG_V];
      // Unconditional
      default: taken = 1'b1;
    endcase
  end

  // Offset counts words
  assign target = dx.pcPlus2 + {{6{dx.offset[8]}}, dx.offset, 1'b0};
  assign redirect = dx.valid && dx.op == cpuPkg::OP_B && taken;

  // Execute/result register
  always_ff @(posedge clk) begin
    if (rst) begin
      xr.valid <= 1'b0;
      xr.wrEn <= 1'b0;
      xr.halt <= 1'b0;
    end else begin
      xr.valid <= dx.valid;
      xr.wrEn <= dx.valid && writes;
      xr.halt <= dx.valid && dx.op == cpuPkg::OP_HLT;
    end
  end

  always_ff @(posedge clk) begin
    xr.rd <= dx.rd;
    xr.data <= aluOut;
  end

  redirectNeedsValid: assert property (@(posedge clk) disable iff (rst) redirect |-> dx.valid);

endmodule

`default_nettype wire

//--- design/fetchUnit.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module fetchUnit (
  input wire clk,
  input wire rst,
  // Program load port, word addressed
  input wire progWe,
  input wire cpuPkg::word_t progAddr,
  input wire cpuPkg::word_t progData,
  // Taken branch from execute
  input wire redirect,
  input wire cpuPkg::word_t target,
  output cpuPkg::word_t pc,
  output cpuPkg::word_t instrD,
  output cpuPkg::word_t pcPlus2D,
  output logic validD
);

  localparam int addrBits = $clog2(`CPU_IMEM_DEPTH);

  cpuPkg::word_t imem [`CPU_IMEM_DEPTH];
  cpuPkg::word_t instrF;
  cpuPkg::word_t pcPlus2F;
  logic hltF;

  ////////////////////
  // Instruction memory
  ////////////////////

  always_ff @(posedge clk) begin
    if (progWe) begin
      imem[progAddr[addrBits-1:0]] <= progData;
    end
  end

  // Byte PC, so drop bit 0
  assign instrF = imem[pc[addrBits:1]];
  assign pcPlus2F = pc + 16'd2;
  assign hltF = instrF[15:12] == cpuPkg::OP_HLT;

  ////////////////////
  // PC
  ////////////////////

  // Redirect wins over the halt freeze
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `CPU_RESET_PC;
    end else if (redirect) begin
      pc <= target;
    end else if (!hltF) begin
      pc <= pcPlus2F;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      validD <= 1'b0;
    end else begin
      validD <= !redirect;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    instrD <= instrF;
    pcPlus2D <= pcPlus2F;
  end

  // Program writes must land inside the array
  progAddrInRange: assert property (@(posedge clk) progWe |-> progAddr < `CPU_IMEM_DEPTH);

endmodule

`default_nettype wire

//--- design/pipeIf.sv
`timescale 1ns/1ns
`default_nettype none

// Decode to execute pipeline register contents
interface decodeExecuteIf;
  logic valid;
  cpuPkg::opcode_t op;
  cpuPkg::regIdx_t rd;
  cpuPkg::regIdx_t rsNum;
  cpuPkg::word_t rsVal;
  cpuPkg::word_t rtVal;
  // Low byte of the instruction, also holds rt and shift amount
  logic [7:0] imm8;
  cpuPkg::cond_t cond;
  // Signed word offset for B
  logic [8:0] offset;
  cpuPkg::word_t pcPlus2;

  modport source (output valid, op, rd, rsNum, rsVal, rtVal, imm8, cond, offset, pcPlus2);
  modport sink (input valid, op, rd, rsNum, rsVal, rtVal, imm8, cond, offset, pcPlus2);
endinterface

// Execute to result pipeline register contents
interface executeResultIf;
  logic valid;
  // Instruction writes rd
  logic wrEn;
  cpuPkg::regIdx_t rd;
  cpuPkg::word_t data;
  logic halt;

  // Execute also reads its own outputs for forwarding
  modport source (output valid, wrEn, rd, data, halt);
  modport sink (input valid, wrEn, rd, data, halt);
endinterface

`default_nettype wire

//--- design/resultStage.sv
`timescale 1ns/1ns
`default_nettype none

module resultStage (
  input wire clk,
  input wire rst,
  executeResultIf.sink xr,
  output logic regWe,
  output cpuPkg::regIdx_t regNum,
  output cpuPkg::word_t regData,
  output logic wbEn,
  output cpuPkg::regIdx_t wbReg,
  output cpuPkg::word_t wbData,
  output logic hlt
);

  logic retire;
  logic haltSeen;

  // One strobe per writing instruction
  assign retire = xr.valid && xr.wrEn;

  // Register file side
  assign regWe = retire;
  assign regNum = xr.rd;
  assign regData = xr.data;

  // Retire port, same cycle as the write
  assign wbEn = retire;
  assign wbReg = xr.rd;
  assign wbData = xr.data;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      haltSeen <= 1'b0;
    end else if (xr.valid && xr.halt) begin
      haltSeen <= 1'b1;
    end
  end

  // High while HLT sits in this stage and after
  assign hlt = haltSeen || (xr.valid && xr.halt);

  noWriteAfterHalt: assert property (@(posedge clk) disable iff (rst) hlt |-> !wbEn);
  retireMatchesWrite: assert property (@(posedge clk) disable iff (rst) wbEn == regWe);

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/cpuPkg.sv
design/pipeIf.sv
design/fetchUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/cpu.sv
tb/cpuTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module cpuTb -o cpuSim \
  > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/cpuSim > sim.log 2>&1
grep -q "Result: FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

//--- tb/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module cpuTb;

  localparam int progMax = `CPU_IMEM_DEPTH;
  // Cycles allowed between two retire strobes
  localparam int writeTimeout = 20;
  localparam int haltWatch = 10;

  logic clk;
  logic rst;
  logic progWe;
  cpuPkg::word_t progAddr;
  cpuPkg::word_t progData;
  cpuPkg::word_t pc;
  logic hlt;
  logic wbEn;
  cpuPkg::regIdx_t wbReg;
  cpuPkg::word_t wbData;

  integer seed;
  cpuPkg::word_t prog [progMax];
  int progLen;
  int hltIdx;
  // Recent destinations, to build dependent pairs
  cpuPkg::regIdx_t lastRd;
  cpuPkg::regIdx_t prevRd;
  // Expected retire stream, mask marks bits the model knows
  cpuPkg::regIdx_t expReg [$];
  cpuPkg::word_t expData [$];
  cpuPkg::word_t expMask [$];

  cpu uut (
    .clk(clk), .rst(rst),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .pc(pc), .hlt(hlt),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
  );

  always #50 clk = !clk;

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  ////////////////////
  // Program builder
  ////////////////////

  function automatic cpuPkg::word_t aluWord(cpuPkg::opcode_t op, cpuPkg::regIdx_t rd,
                                            cpuPkg::regIdx_t rs, logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic cpuPkg::word_t byteLoadWord(cpuPkg::opcode_t op, cpuPkg::regIdx_t rd,
                                                 logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic cpuPkg::word_t branchWord(cpuPkg::cond_t cond, logic [8:0] off);
    return {cpuPkg::OP_B, cond, off};
  endfunction

  task automatic append(input cpuPkg::word_t w);
    prog[progLen] = w;
    progLen++;
  endtask

  // Random ALU or byte load, sources lean on the last two destinations
  task automatic appendRandomAlu();
    logic [31:0] rnd;
    cpuPkg::opcode_t op;
    cpuPkg::regIdx_t rd;
    cpuPkg::regIdx_t rs;
    logic [3:0] rt;
    rnd = $random(seed);
    case (rnd[18:16])
      3'd0: op = cpuPkg::OP_ADD;
      3'd1: op = cpuPkg::OP_SUB;
      3'd2: op = cpuPkg::OP_XOR;
      3'd3: op = cpuPkg::OP_SLL;
      3'd4: op = cpuPkg::OP_SRA;
      3'd5: op = cpuPkg::OP_LLB;
      3'd6: op = cpuPkg::OP_LHB;
      default: op = cpuPkg::OP_SUB;
    endcase
    rd = rnd[3:0];
    rs = rnd[4] ? lastRd : rnd[11:8];
    rt = rnd[5] ? prevRd : rnd[15:12];
    if (op == cpuPkg::OP_LLB || op == cpuPkg::OP_LHB) begin
      append(byteLoadWord(op, rd, rnd[27:20]));
    end else begin
      append(aluWord(op, rd, rs, rt));
    end
    prevRd = lastRd;
    lastRd = rd;
  endtask

  task automatic buildProgram();
    logic [31:0] rnd;
    progLen = 0;
    lastRd = '0;
    prevRd = '0;
    // Each register from two random bytes
    for (int k = 0; k < 16; k++) begin
      rnd = $random(seed);
      append(byteLoadWord(cpuPkg::OP_LLB, cpuPkg::regIdx_t'(k), rnd[7:0]));
      append(byteLoadWord(cpuPkg::OP_LHB, cpuPkg::regIdx_t'(k), rnd[15:8]));
    end
    for (int i = 0; i < 40; i++) begin
      appendRandomAlu();
    end
    // Flag setter, branch over two shadow slots
    for (int round = 0; round < 3; round++) begin
      for (int c = 0; c < 8; c++) begin
        rnd = $random(seed);
        if (round == 1) begin
          // x - x, so Z set and N, V clear
          append(aluWord(cpuPkg::OP_SUB, rnd[7:4], rnd[11:8], rnd[11:8]));
        end else begin
          append(aluWord(rnd[0] ? cpuPkg::OP_SUB : cpuPkg::OP_ADD, rnd[7:4], rnd[11:8],
                         rnd[15:12]));
        end
        append(branchWord(cpuPkg::cond_t'(c), 9'd2));
        appendRandomAlu();
        appendRandomAlu();
      end
    end
    append({cpuPkg::OP_HLT, 12'h000});
  endtask

  ////////////////////
  // ISA model
  ////////////////////

  // Flags are Z, V, N from the top bit
  function automatic logic branchTaken(cpuPkg::cond_t cond, cpuPkg::flags_t fl);
    case (cond)
      3'b000: return !fl[2];
      3'b001: return fl[2];
      3'b010: return !fl[2] && !fl[0];
      3'b011: return fl[0];
      3'b100: return fl[2] || (!fl[2] && !fl[0]);
      3'b101: return fl[0] || fl[2];
      3'b110: return fl[1];
      default: return 1'b1;
    endcase
  endfunction

  task automatic runModel();
    cpuPkg::word_t regs [16];
    cpuPkg::word_t known [16];
    cpuPkg::flags_t fl;
    cpuPkg::word_t ins;
    cpuPkg::word_t a;
    cpuPkg::word_t b;
    cpuPkg::word_t res;
    cpuPkg::word_t mask;
    cpuPkg::regIdx_t rd;
    logic wr;
    int sum;
    int idx;
    for (int r = 0; r < 16; r++) begin
      regs[r] = '0;
      known[r] = '0;
    end
    fl = '0;
    idx = 0;
    while (idx < progLen && prog[idx][15:12] != cpuPkg::OP_HLT) begin
      ins = prog[idx];
      rd = ins[11:8];
      a = regs[ins[7:4]];
      b = regs[ins[3:0]];
      res = '0;
      mask = 16'hffff;
      wr = 1'b1;
      case (ins[15:12])
        cpuPkg::OP_ADD: begin
          res = a + b;
          sum = int'($signed(a)) + int'($signed(b));
          fl = {res == '0, (sum > 32767) || (sum < -32768), res[15]};
        end
        cpuPkg::OP_SUB: begin
          res = a - b;
          sum = int'($signed(a)) - int'($signed(b));
          fl = {res == '0, (sum > 32767) || (sum < -32768), res[15]};
        end
        cpuPkg::OP_XOR: res = a ^ b;
        cpuPkg::OP_SLL: res = a << ins[3:0];
        cpuPkg::OP_SRA: res = $signed(a) >>> ins[3:0];
        cpuPkg::OP_LLB: begin
          res = {regs[rd][15:8], ins[7:0]};
          mask = {known[rd][15:8], 8'hff};
        end
        cpuPkg::OP_LHB: begin
          res = {ins[7:0], regs[rd][7:0]};
          mask = {8'hff, known[rd][7:0]};
        end
        default: wr = 1'b0;
      endcase
      // Z only for XOR and the shifts
      if (ins[15:12] inside {cpuPkg::OP_XOR, cpuPkg::OP_SLL, cpuPkg::OP_SRA}) begin
        fl[2] = res == '0;
      end
      if (wr) begin
        regs[rd] = res;
        known[rd] = mask;
        expReg.push_back(rd);
        expData.push_back(res);
        expMask.push_back(mask);
      end
      if (ins[15:12] == cpuPkg::OP_B && branchTaken(ins[11:9], fl)) begin
        idx = idx + 1 + int'($signed(ins[8:0]));
      end else begin
        idx = idx + 1;
      end
    end
    assert (idx < progLen) else abortRun("model ran past the end of the program");
    hltIdx = idx;
  endtask

  ////////////////////
  // Stimulus and checks
  ////////////////////

  // One word per cycle while rst is high
  task automatic loadProgram();
    for (int i = 0; i < progLen; i++) begin
      @(posedge clk);
      #1;
      progWe = 1'b1;
      progAddr = cpuPkg::word_t'(i);
      progData = prog[i];
    end
    @(posedge clk);
    #1;
    progWe = 1'b0;
  endtask

  task automatic checkWrites();
    int waitCycles;
    int count;
    count = 0;
    while (!hlt) begin
      waitCycles = 0;
      do begin
        @(negedge clk);
        waitCycles++;
      end while (!wbEn && !hlt && waitCycles < writeTimeout);
      assert (wbEn || hlt) else abortRun("timeout waiting for a register write or halt");
      if (wbEn) begin
        assert (expData.size() > 0) else abortRun("register write the model does not expect");
        assert (wbReg == expReg[0]) else
          abortRun($sformatf("FAILED wbReg[%0d] expected %0d actual %0d", count, expReg[0],
                             wbReg));
        assert ((wbData & expMask[0]) == (expData[0] & expMask[0])) else
          abortRun($sformatf("FAILED wbData[%0d] expected %h actual %h", count,
                             expData[0] & expMask[0], wbData & expMask[0]));
        void'(expReg.pop_front());
        void'(expData.pop_front());
        void'(expMask.pop_front());
        count++;
      end
    end
  endtask

  // PC frozen on the HLT word, nothing retires
  task automatic checkHalt();
    cpuPkg::word_t pcHeld;
    pcHeld = pc;
    assert (pcHeld == cpuPkg::word_t'(hltIdx * 2)) else
      abortRun($sformatf("FAILED haltPc expected %h actual %h", hltIdx * 2, pcHeld));
    repeat (haltWatch) begin
      @(negedge clk);
      assert (hlt) else abortRun("hlt dropped before reset");
      assert (!wbEn) else abortRun("register write after halt");
      assert (pc == pcHeld) else
        abortRun($sformatf("FAILED heldPc expected %h actual %h", pcHeld, pc));
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    seed = 32'hf5a6d521;
    buildProgram();
    runModel();
    loadProgram();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (pc == `CPU_RESET_PC) else
      abortRun($sformatf("FAILED resetPc expected %h actual %h", `CPU_RESET_PC, pc));
    assert (!hlt && !wbEn) else abortRun("hlt or wbEn high right after reset");
    checkWrites();
    checkHalt();
    if (expData.size() != 0) begin
      abortRun($sformatf("%0d expected writes never retired", expData.size()));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
